// File: design/cell_memory.sv
module cell_memory (
    input  logic                               CLOCK_50,
    input  logic                               wr_en,
    input  logic [sketch_grid_pkg::coord_w-1:0] wr_x,
    input  logic [sketch_grid_pkg::coord_w-1:0] wr_y,
    input  logic                               wr_data,  // 1 = cell set
    input  logic [sketch_grid_pkg::coord_w-1:0] rd_x,
    input  logic [sketch_grid_pkg::coord_w-1:0] rd_y,
    output logic                               rd_set    // Mark of rd_x, rd_y one cycle later
);

    import sketch_grid_pkg::*;

    logic                             mem [cell_count];  // Row-major cell marks
    logic [$clog2(cell_count)-1:0]    wr_addr;
    logic [$clog2(cell_count)-1:0]    rd_addr;

    // Linear address y * 28 + x on both ports
    assign wr_addr = ($clog2(cell_count))'(wr_y * grid_size + wr_x);
    assign rd_addr = ($clog2(cell_count))'(rd_y * grid_size + rd_x);

    always_ff @(posedge CLOCK_50) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read, same lookup the display colour path makes
    always_ff @(posedge CLOCK_50) begin
        rd_set <= mem[rd_addr];
    end

endmodule

// File: design/cursor_ctrl.sv
module cursor_ctrl (
    input  logic                               CLOCK_50,
    input  logic                               rst_n,
    input  logic [3:0]                         KEY,      // Active low push keys
    input  logic                               tick,     // Auto-repeat step
    output logic                               press,    // Any new key press this cycle
    output logic                               held,     // Any key down
    output logic [sketch_grid_pkg::coord_w-1:0] cursor_x,
    output logic [sketch_grid_pkg::coord_w-1:0] cursor_y
);

    import sketch_grid_pkg::*;

    logic [3:0] key_q;                                   // Registered keys, 1 = pressed
    logic [3:0] key_prev;                                // Previous sample of key_q
    logic       step;                                    // Move this cycle
    logic       go_right, go_left, go_down, go_up;

    assign press = |(key_q & ~key_prev);                 // Rising edge on any key
    assign held  = |key_q;
    assign step  = press | tick;

    // Opposite keys cancel, and each axis stops at the grid edge
    assign go_right = key_q[key_right] & ~key_q[key_left]
                      & (cursor_x != coord_w'(grid_size - 1));
    assign go_left  = key_q[key_left] & ~key_q[key_right] & (cursor_x != '0);
    assign go_down  = key_q[key_down] & ~key_q[key_up]
                      & (cursor_y != coord_w'(grid_size - 1));
    assign go_up    = key_q[key_up] & ~key_q[key_down] & (cursor_y != '0);

    always_ff @(posedge CLOCK_50) begin
        if (!rst_n) begin
            key_q    <= '0;
            key_prev <= '0;
            cursor_x <= coord_w'(cursor_home);
            cursor_y <= coord_w'(cursor_home);
        end else begin
            key_q    <= ~KEY;                            // Flip to active high
            key_prev <= key_q;
            if (step) begin
                if (go_right) cursor_x <= cursor_x + 1'b1;
                if (go_left)  cursor_x <= cursor_x - 1'b1;
                if (go_down)  cursor_y <= cursor_y + 1'b1;
                if (go_up)    cursor_y <= cursor_y - 1'b1;
            end
        end
    end

endmodule

// File: design/hex_decoder.sv
module hex_decoder (
    input  logic [3:0] nibble,
    output logic [6:0] seg                               // Active low, seg[0] is segment a
);

    always_comb begin
        case (nibble)
            4'h0:    seg = 7'b1000000;
            4'h1:    seg = 7'b1111001;
            4'h2:    seg = 7'b0100100;
            4'h3:    seg = 7'b0110000;
            4'h4:    seg = 7'b0011001;
            4'h5:    seg = 7'b0010010;
            4'h6:    seg = 7'b0000010;
            4'h7:    seg = 7'b1111000;
            4'h8:    seg = 7'b0000000;
            4'h9:    seg = 7'b0010000;
            4'hA:    seg = 7'b0001000;
            4'hB:    seg = 7'b0000011;               // Lower case b
            4'hC:    seg = 7'b1000110;
            4'hD:    seg = 7'b0100001;               // Lower case d
            4'hE:    seg = 7'b0000110;
            4'hF:    seg = 7'b0001110;
            default: seg = 7'b1111111;               // Blank
        endcase
    end

endmodule

// File: design/key_repeat_timer.sv
module key_repeat_timer #(
    parameter int REPEAT_CYCLES = sketch_grid_pkg::repeat_default
) (
    input  logic CLOCK_50,
    input  logic rst_n,
    input  logic press,                                 // New key press, restarts the period
    input  logic held,                                  // Any key still down
    output logic tick                                   // One pulse per elapsed period
);

    logic [$clog2(REPEAT_CYCLES)-1:0] count;            // Cycles since press or last tick
    logic                             wrap;             // Count at end of period

    assign wrap = (count == ($clog2(REPEAT_CYCLES))'(REPEAT_CYCLES - 1));

    // A press wins over a tick in the same cycle, the cursor moves once
    assign tick = held & ~press & wrap;

    always_ff @(posedge CLOCK_50) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            if (press) begin
                count <= '0;                            // Period starts on the press
            end else if (held) begin
                if (wrap) begin
                    count <= '0;                        // Wrap with the tick
                end else begin
                    count <= count + 1'b1;
                end
            end else begin
                count <= '0;                            // Idle while no key is down
            end
        end
    end

endmodule

// File: design/plot_fsm.sv
module plot_fsm (
    input  logic                               CLOCK_50,
    input  logic                               rst_n,
    input  logic [1:0]                         SW,          // SW[1] stamp, SW[0] erase
    input  logic [sketch_grid_pkg::coord_w-1:0] cursor_x,
    input  logic [sketch_grid_pkg::coord_w-1:0] cursor_y,
    input  logic                               plot_ready,  // Frame buffer accepts
    output logic                               plot_valid,
    output logic [sketch_grid_pkg::scr_x_w-1:0] plot_x,
    output logic [sketch_grid_pkg::scr_y_w-1:0] plot_y,
    output logic [2:0]                         plot_colour,
    output logic                               wr_en,
    output logic [sketch_grid_pkg::coord_w-1:0] wr_x,
    output logic [sketch_grid_pkg::coord_w-1:0] wr_y,
    output logic                               wr_data
);

    import sketch_grid_pkg::*;

    plot_state_t        state;
    logic [coord_w-1:0] cell_x;                          // Cell being drawn
    logic [coord_w-1:0] cell_y;
    logic [1:0]         sub_x;                           // Pixel inside the cell
    logic [1:0]         sub_y;
    logic [1:0]         sw_q;                            // Previous switch sample
    logic [1:0]         sw_rise;
    logic               xfer;                            // Plot write accepted this edge
    logic               last_px;                         // Bottom-right pixel of a cell
    logic               last_col;
    logic               last_cell;                       // Cell 27,27

    assign sw_rise   = SW & ~sw_q;
    assign xfer      = plot_valid & plot_ready;
    assign last_px   = (sub_x == 2'(cell_px - 1)) && (sub_y == 2'(cell_px - 1));
    assign last_col  = (cell_x == coord_w'(grid_size - 1));
    assign last_cell = last_col && (cell_y == coord_w'(grid_size - 1));

    // Only counters feed the coordinates, so they hold while stalled
    assign plot_x = scr_x_w'(grid_off_x + cell_x * cell_px + sub_x);
    assign plot_y = scr_y_w'(grid_off_y + cell_y * cell_px + sub_y);

    // Sweep clears each cell on its last pixel, commit writes the latched cell
    assign wr_en   = (state == commit) | ((state == clear_sweep) & xfer & last_px);
    assign wr_x    = cell_x;
    assign wr_y    = cell_y;
    assign wr_data = (plot_colour == colour_black);     // Black marks, white clears

    always_ff @(posedge CLOCK_50) begin
        if (!rst_n) begin
            state       <= clear_sweep;
            plot_valid  <= 1'b0;
            plot_colour <= colour_white;
            cell_x      <= '0;
            cell_y      <= '0;
            sub_x       <= '0;
            sub_y       <= '0;
            sw_q        <= SW;                           // No edge from a switch left high
        end else begin
            sw_q <= SW;

            // Pixel walk, x fastest then y, shared by sweep and stamp
            if (xfer) begin
                sub_x <= sub_x + 1'b1;
                if (sub_x == 2'(cell_px - 1)) begin
                    sub_y <= sub_y + 1'b1;
                end
            end

            case (state)
                clear_sweep: begin
                    if (!plot_valid) begin
                        plot_valid <= 1'b1;              // Present pixel 10,10
                    end else if (xfer && last_px) begin
                        if (last_cell) begin
                            plot_valid <= 1'b0;          // 12544 writes done
                            cell_x     <= '0;
                            cell_y     <= '0;
                            state      <= idle;
                        end else if (last_col) begin
                            cell_x <= '0;                // Next row of cells
                            cell_y <= cell_y + 1'b1;
                        end else begin
                            cell_x <= cell_x + 1'b1;
                        end
                    end
                end

                idle: begin
                    if (sw_rise[1]) begin
                        cell_x      <= cursor_x;         // Stamp takes priority
                        cell_y      <= cursor_y;
                        plot_colour <= colour_black;
                        plot_valid  <= 1'b1;
                        state       <= stamp;
                    end else if (sw_rise[0]) begin
                        cell_x      <= cursor_x;         // Erase paints white
                        cell_y      <= cursor_y;
                        plot_colour <= colour_white;
                        plot_valid  <= 1'b1;
                        state       <= stamp;
                    end
                end

                stamp: begin
                    if (xfer && last_px) begin
                        plot_valid <= 1'b0;              // 16th pixel accepted
                        state      <= commit;
                    end
                end

                commit: begin
                    state <= idle;                       // Memory written this cycle
                end

                default: begin
                    state <= idle;
                end
            endcase
        end
    end

endmodule

// File: design/sketch_grid_pkg.sv
package sketch_grid_pkg;

    // Grid geometry
    localparam int grid_size  = 28;                     // Cells per side
    localparam int cell_px    = 4;                      // Pixels per cell side
    localparam int grid_off_x = 10;                     // Screen x of cell 0,0
    localparam int grid_off_y = 10;                     // Screen y of cell 0,0
    localparam int cell_count = grid_size * grid_size;  // One mark bit per cell

    // Coordinate widths
    localparam int coord_w = 5;                         // Holds 0..27
    localparam int scr_x_w = 8;                         // 160 columns
    localparam int scr_y_w = 7;                         // 120 rows

    // Plot colours, 3-bit RGB
    localparam logic [2:0] colour_white = 3'b111;
    localparam logic [2:0] colour_black = 3'b000;

    // Bit index of each push key inside KEY
    localparam int key_right = 0;
    localparam int key_left  = 1;
    localparam int key_down  = 2;                       // Screen y grows downward
    localparam int key_up    = 3;

    localparam int cursor_home = 14;                    // Middle of the grid on both axes

    localparam int repeat_default = 100000;             // 2 ms auto-repeat at 50 MHz

    // Plot FSM states
    typedef enum logic [1:0] {
        clear_sweep,                                    // White wipe of the whole grid
        idle,                                           // Waiting for a switch edge
        stamp,                                          // 16 pixels of one cell
        commit                                          // Memory bit update
    } plot_state_t;

endpackage

// File: design/sketch_grid_top.sv
module sketch_grid_top #(
    parameter int REPEAT_CYCLES = sketch_grid_pkg::repeat_default
) (
    input  logic                               CLOCK_50,
    input  logic                               rst_n,
    input  logic [3:0]                         KEY,         // Active low cursor keys
    input  logic [1:0]                         SW,          // SW[1] stamp, SW[0] erase
    input  logic                               plot_ready,
    input  logic [sketch_grid_pkg::coord_w-1:0] rd_x,       // Cell to look up
    input  logic [sketch_grid_pkg::coord_w-1:0] rd_y,
    output logic                               plot_valid,
    output logic [sketch_grid_pkg::scr_x_w-1:0] plot_x,
    output logic [sketch_grid_pkg::scr_y_w-1:0] plot_y,
    output logic [2:0]                         plot_colour,
    output logic                               rd_set,
    output logic [6:0]                         HEX0,        // Cursor x low digit
    output logic [6:0]                         HEX1,        // Cursor x top bit
    output logic [6:0]                         HEX2,        // Cursor y low digit
    output logic [6:0]                         HEX3         // Cursor y top bit
);

    import sketch_grid_pkg::*;

    logic               tick;
    logic               press;
    logic               held;
    logic [coord_w-1:0] cursor_x;
    logic [coord_w-1:0] cursor_y;
    logic               wr_en;
    logic [coord_w-1:0] wr_x;
    logic [coord_w-1:0] wr_y;
    logic               wr_data;

    key_repeat_timer #(
        .REPEAT_CYCLES (REPEAT_CYCLES)
    ) key_repeat_timer_inst (
        .CLOCK_50 (CLOCK_50),
        .rst_n    (rst_n),
        .press    (press),
        .held     (held),
        .tick     (tick)
    );

    cursor_ctrl cursor_ctrl_inst (
        .CLOCK_50 (CLOCK_50),
        .rst_n    (rst_n),
        .KEY      (KEY),
        .tick     (tick),
        .press    (press),
        .held     (held),
        .cursor_x (cursor_x),
        .cursor_y (cursor_y)
    );

    plot_fsm plot_fsm_inst (
        .CLOCK_50    (CLOCK_50),
        .rst_n       (rst_n),
        .SW          (SW),
        .cursor_x    (cursor_x),
        .cursor_y    (cursor_y),
        .plot_ready  (plot_ready),
        .plot_valid  (plot_valid),
        .plot_x      (plot_x),
        .plot_y      (plot_y),
        .plot_colour (plot_colour),
        .wr_en       (wr_en),
        .wr_x        (wr_x),
        .wr_y        (wr_y),
        .wr_data     (wr_data)
    );

    cell_memory cell_memory_inst (
        .CLOCK_50 (CLOCK_50),
        .wr_en    (wr_en),
        .wr_x     (wr_x),
        .wr_y     (wr_y),
        .wr_data  (wr_data),
        .rd_x     (rd_x),
        .rd_y     (rd_y),
        .rd_set   (rd_set)
    );

    // Coordinates go up to 27, so the high digit is 0 or 1
    hex_decoder hex0_inst (.nibble (cursor_x[3:0]),           .seg (HEX0));
    hex_decoder hex1_inst (.nibble ({3'b000, cursor_x[4]}),   .seg (HEX1));
    hex_decoder hex2_inst (.nibble (cursor_y[3:0]),           .seg (HEX2));
    hex_decoder hex3_inst (.nibble ({3'b000, cursor_y[4]}),   .seg (HEX3));

endmodule

// File: testbench/tb_sketch_grid.sv
module tb_sketch_grid;

    import sketch_grid_pkg::*;

    localparam int repeat_cycles  = 20;                  // Short period for simulation
    localparam int sweep_writes   = cell_count * cell_px * cell_px;
    localparam int act_none       = 0;
    localparam int act_stamp      = 1;                   // SW[1] edge
    localparam int act_erase      = 2;                   // SW[0] edge
    localparam int act_erase_edge = 3;                   // SW[0] edge, SW[1] edge mid-stamp
    localparam int row_count      = 16;

    // Active-low seven-segment codes for 0 to F, digit 0 in the low bits
    localparam logic [111:0] seg_codes = {
        7'h0e, 7'h06, 7'h21, 7'h46, 7'h03, 7'h08, 7'h10, 7'h00,
        7'h78, 7'h02, 7'h12, 7'h19, 7'h30, 7'h24, 7'h79, 7'h40
    };

    typedef struct packed {
        int keys, hold, act, rep;                        // Key mask (1 = pressed), hold, action, step check
        int cx, cy;                                      // Expected cursor
        int r0x, r0y, r0v, r1x, r1y, r1v, r2x, r2y, r2v; // Three reads, negative mark skips
    } row_t;

    logic                 CLOCK_50;
    logic                 rst_n;
    logic [3:0]           KEY;
    logic [1:0]           SW;
    logic                 plot_ready;
    logic [coord_w-1:0]   rd_x;
    logic [coord_w-1:0]   rd_y;
    logic                 plot_valid;
    logic [scr_x_w-1:0]   plot_x;
    logic [scr_y_w-1:0]   plot_y;
    logic [2:0]           plot_colour;
    logic                 rd_set;
    logic [6:0]           HEX0, HEX1, HEX2, HEX3;

    row_t                 rows [row_count];
    logic [17:0]          exp_q [$];                     // Predicted writes, {x, y, colour}
    logic [17:0]          exp_px;
    int                   xfer_count;                    // Accepted plot writes
    int                   step_count;                    // Cursor moves seen on the HEX digits
    logic [27:0]          hex_last;
    logic                 stall_prev;                    // Write pending at the last sample
    logic [17:0]          stall_px;

    sketch_grid_top #(
        .REPEAT_CYCLES (repeat_cycles)
    ) sketch_grid_top_inst (
        .CLOCK_50 (CLOCK_50), .rst_n (rst_n), .KEY (KEY), .SW (SW),
        .plot_ready (plot_ready), .rd_x (rd_x), .rd_y (rd_y),
        .plot_valid (plot_valid), .plot_x (plot_x), .plot_y (plot_y),
        .plot_colour (plot_colour), .rd_set (rd_set),
        .HEX0 (HEX0), .HEX1 (HEX1), .HEX2 (HEX2), .HEX3 (HEX3)
    );

    always #2 CLOCK_50 = ~CLOCK_50;                      // Period 4

    // Random back-pressure on the plot port
    initial begin
        void'($urandom(32'hf1f8));
        forever begin
            @(posedge CLOCK_50);
            plot_ready <= ($urandom % 4) != 0;           // Ready three times in four
        end
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input int got, input int exp);
        $display("mismatch at %0t: %s = %0h, expected %0h", $time, name, got, exp);
        abort_run("value check failed");
    endtask

    function automatic logic [6:0] seg_pattern(input int n);
        return seg_codes[n * 7 +: 7];                    // Segment a in bit 0
    endfunction

    // The 16 pixels of one cell, x fastest then y
    task automatic push_cell(input int cx, input int cy, input logic [2:0] colour);
        for (int sy = 0; sy < cell_px; sy++) begin
            for (int sx = 0; sx < cell_px; sx++) begin
                exp_q.push_back({scr_x_w'(grid_off_x + cx * cell_px + sx),
                                 scr_y_w'(grid_off_y + cy * cell_px + sy), colour});
            end
        end
    endtask

    task automatic wait_plot_idle(input int limit, input string what);
        int n;
        n = 0;
        while (!plot_valid) begin                        // First write presented
            @(negedge CLOCK_50);
            n++;
            if (n > limit) abort_run({"timeout waiting for ", what, " to start"});
        end
        n = 0;
        while (plot_valid) begin                         // Last write taken
            @(negedge CLOCK_50);
            n++;
            if (n > limit) abort_run({"timeout waiting for ", what, " to finish"});
        end
        repeat (3) @(posedge CLOCK_50);                  // Commit cycle writes the mark
    endtask

    task automatic hold_keys(input int mask, input int cycles);
        step_count = 0;
        @(posedge CLOCK_50);
        KEY <= ~mask[3:0];
        repeat (cycles) @(posedge CLOCK_50);
        KEY <= 4'hf;
        repeat (6) @(posedge CLOCK_50);                  // Let the last step land
    endtask

    task automatic check_cursor(input int cx, input int cy);
        @(negedge CLOCK_50);
        assert (HEX0 == seg_pattern(cx % 16))
            else report_mismatch("HEX0", HEX0, seg_pattern(cx % 16));
        assert (HEX1 == seg_pattern(cx / 16))
            else report_mismatch("HEX1", HEX1, seg_pattern(cx / 16));
        assert (HEX2 == seg_pattern(cy % 16))
            else report_mismatch("HEX2", HEX2, seg_pattern(cy % 16));
        assert (HEX3 == seg_pattern(cy / 16))
            else report_mismatch("HEX3", HEX3, seg_pattern(cy / 16));
    endtask

    task automatic check_mark(input int cx, input int cy, input int v);
        if (v >= 0) begin                                // Negative mark means no read
            @(posedge CLOCK_50);
            rd_x <= coord_w'(cx);
            rd_y <= coord_w'(cy);
            @(posedge CLOCK_50);
            @(negedge CLOCK_50);                         // rd_set one cycle after the address
            assert (rd_set === v[0]) else report_mismatch("rd_set", rd_set, v);
        end
    endtask

    task automatic run_switch(input int act, input int cx, input int cy);
        int n;
        n = 0;
        push_cell(cx, cy, (act == act_stamp) ? colour_black : colour_white);
        @(posedge CLOCK_50);
        SW <= (act == act_stamp) ? 2'b10 : 2'b01;
        if (act == act_erase_edge) begin
            while (!plot_valid) begin
                @(negedge CLOCK_50);
                n++;
                if (n > 50) abort_run("timeout waiting for the erase to start");
            end
            @(posedge CLOCK_50);
            SW <= 2'b11;                                 // Edge while busy, must be ignored
        end
        repeat (2) @(posedge CLOCK_50);
        SW <= 2'b00;
        wait_plot_idle(2000, "a cell write");
        assert (exp_q.size() == 0)
            else report_mismatch("pending cell writes", exp_q.size(), 0);
    endtask

    // Plot port reference check, sampled mid-cycle
    always @(negedge CLOCK_50) begin
        if (rst_n) begin
            if (stall_prev) begin
                assert (plot_valid)
                    else abort_run("plot_valid dropped before its write was taken");
                assert ({plot_x, plot_y, plot_colour} == stall_px)
                    else report_mismatch("plot data while stalled", {plot_x, plot_y, plot_colour},
                                         stall_px);
            end
            if (plot_valid && plot_ready) begin
                assert (exp_q.size() != 0)
                    else abort_run("plot write arrived with none expected");
                exp_px = exp_q.pop_front();
                assert (plot_x == exp_px[17:10])
                    else report_mismatch("plot_x", plot_x, exp_px[17:10]);
                assert (plot_y == exp_px[9:3])
                    else report_mismatch("plot_y", plot_y, exp_px[9:3]);
                assert (plot_colour == exp_px[2:0])
                    else report_mismatch("plot_colour", plot_colour, exp_px[2:0]);
                xfer_count++;
            end
            stall_prev = plot_valid && !plot_ready;
            stall_px   = {plot_x, plot_y, plot_colour};
        end
        if ({HEX3, HEX2, HEX1, HEX0} != hex_last) step_count++;   // One change per cursor move
        hex_last = {HEX3, HEX2, HEX1, HEX0};
    end

    initial begin
        int exp_steps;
        CLOCK_50   = 1'b0;
        rst_n      = 1'b0;
        KEY        = 4'hf;                               // All keys released
        SW         = 2'b00;
        plot_ready = 1'b0;
        rd_x       = '0;
        rd_y       = '0;
        xfer_count = 0;
        step_count = 0;
        stall_prev = 1'b0;
        hex_last   = '0;

        rows[0]  = '{4'h0, 0, act_none, 0, 14, 14, 0, 0, 0, 27, 27, 0, 14, 14, 0};
        rows[1]  = '{4'h1, 3, act_none, 0, 15, 14, 0, 0, -1, 0, 0, -1, 0, 0, -1};
        rows[2]  = '{4'h2, 3, act_none, 0, 14, 14, 0, 0, -1, 0, 0, -1, 0, 0, -1};
        rows[3]  = '{4'h4, 3, act_none, 0, 14, 15, 0, 0, -1, 0, 0, -1, 0, 0, -1};
        rows[4]  = '{4'h8, 3, act_none, 0, 14, 14, 0, 0, -1, 0, 0, -1, 0, 0, -1};
        rows[5]  = '{4'h0, 0, act_stamp, 0, 14, 14, 14, 14, 1, 13, 14, 0, 15, 14, 0};
        rows[6]  = '{4'h1, 70, act_none, 1, 0, 0, 0, 0, -1, 0, 0, -1, 0, 0, -1};
        rows[7]  = '{4'h2, 700, act_none, 0, 0, 14, 0, 0, -1, 0, 0, -1, 0, 0, -1};
        rows[8]  = '{4'h1, 3, act_none, 0, 1, 14, 0, 0, -1, 0, 0, -1, 0, 0, -1};
        rows[9]  = '{4'h1, 3, act_none, 0, 2, 14, 0, 0, -1, 0, 0, -1, 0, 0, -1};
        rows[10] = '{4'h2, 100, act_none, 0, 0, 14, 0, 0, -1, 0, 0, -1, 0, 0, -1};
        rows[11] = '{4'h4, 400, act_none, 0, 0, 27, 0, 0, -1, 0, 0, -1, 0, 0, -1};
        rows[12] = '{4'h0, 0, act_stamp, 0, 0, 27, 0, 27, 1, 1, 27, 0, 0, 26, 0};
        rows[13] = '{4'h3, 3, act_none, 0, 0, 27, 0, 0, -1, 0, 0, -1, 0, 0, -1};
        rows[14] = '{4'h0, 0, act_erase_edge, 0, 0, 27, 0, 27, 0, 14, 14, 1, 27, 27, 0};
        rows[15] = '{4'h8, 3, act_erase, 0, 0, 26, 0, 26, 0, 0, 27, 0, 14, 14, 1};

        for (int cy = 0; cy < grid_size; cy++) begin
            for (int cx = 0; cx < grid_size; cx++) begin
                push_cell(cx, cy, colour_white);         // Row-major clear sweep
            end
        end

        repeat (8) @(posedge CLOCK_50);
        rst_n <= 1'b1;
        wait_plot_idle(80000, "the clear sweep");
        assert (xfer_count == sweep_writes)
            else report_mismatch("sweep writes", xfer_count, sweep_writes);

        for (int i = 0; i < row_count; i++) begin
            if (rows[i].keys != 0) hold_keys(rows[i].keys, rows[i].hold);
            if (rows[i].rep != 0) begin
                exp_steps = 1 + rows[i].hold / repeat_cycles;
                assert (step_count >= exp_steps - 1 && step_count <= exp_steps + 1)
                    else report_mismatch("cursor steps", step_count, exp_steps);
            end else begin
                check_cursor(rows[i].cx, rows[i].cy);
            end
            if (rows[i].act != act_none) run_switch(rows[i].act, rows[i].cx, rows[i].cy);
            check_mark(rows[i].r0x, rows[i].r0y, rows[i].r0v);
            check_mark(rows[i].r1x, rows[i].r1y, rows[i].r1v);
            check_mark(rows[i].r2x, rows[i].r2y, rows[i].r2v);
        end

        repeat (20) @(negedge CLOCK_50);                 // Port must stay quiet
        assert (!plot_valid && exp_q.size() == 0) else abort_run("plot port busy at the end");
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: verilog.f
design/sketch_grid_pkg.sv
design/key_repeat_timer.sv
design/cursor_ctrl.sv
design/cell_memory.sv
design/plot_fsm.sv
design/hex_decoder.sv
design/sketch_grid_top.sv
testbench/tb_sketch_grid.sv
